// File: flist.f
spi_pkg.sv
spi_fifo.sv
spi_regs.sv
spi_shift_engine.sv
spi_master_top.sv
spi_master_assertions.sv
tb_spi_master.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_spi_master
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
SIM_BIN    := obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

// File: tb_spi_master.sv
/* Directed testbench for the SPI master: host register driver, SPI line monitor
   and MISO pattern driver. Run with tb_spi_master as the top module. */
`timescale 1ns/1ps

module tb_spi_master;
    import spi_pkg::*;

    localparam int NUM_SS     = 4;
    localparam int FIFO_DEPTH = 4;
    // Worst case of all tests, words x 32 bits x 2 halves x prescale x 10 ns
    localparam longint WATCH_WORDS = 32;
    localparam longint WATCH_PRESC = 8;
    localparam longint WATCHDOG_NS = WATCH_WORDS * 32 * 2 * WATCH_PRESC * 10 + 50000;

    logic              clk;
    logic              reset_i;
    reg_addr_e         addr_i;
    logic              wr_i;
    logic [31:0]       wdata_i;
    logic              rd_i;
    logic              miso_i;
    logic [31:0]       rdata_o;
    logic              rvalid_o;
    logic              sclk_o;
    logic              mosi_o;
    logic [NUM_SS-1:0] ncs_o;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] rng_state;

    // Line monitor configuration and capture
    logic        cfg_cpol;
    logic        cfg_cpha;
    logic        cfg_lsb;
    int          cfg_width;
    logic [31:0] miso_pat;
    logic        mon_prev;
    int          mon_edges;
    int          drv_edges;
    logic        mon_bits[$];

    spi_master_top #(
        .NUM_SS     (NUM_SS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk(clk), .reset_i(reset_i), .addr_i(addr_i), .wr_i(wr_i), .wdata_i(wdata_i),
        .rd_i(rd_i), .miso_i(miso_i), .rdata_o(rdata_o), .rvalid_o(rvalid_o),
        .sclk_o(sclk_o), .mosi_o(mosi_o), .ncs_o(ncs_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] width_mask(input int width);
        return (width >= 32) ? 32'hFFFF_FFFF : ((32'h1 << width) - 32'h1);
    endfunction

    // Bit j on the wire of a right-aligned word
    function automatic logic line_bit(input logic [31:0] w, input int width,
                                      input logic lsb, input int j);
        return lsb ? w[j] : w[width-1-j];
    endfunction

    function automatic logic [31:0] make_ctrl(input int presc, input int width,
                                              input logic mssa, input logic lsb,
                                              input logic cpol, input logic cpha,
                                              input logic spe, input logic loop);
        logic [31:0] c;
        c = '0;
        c[31:16] = presc[15:0];
        c[15:8]  = width[7:0];
        c[CTRL_MSSA]      = mssa;
        c[CTRL_LSB_FIRST] = lsb;
        c[CTRL_CPOL]      = cpol;
        c[CTRL_CPHA]      = cpha;
        c[CTRL_SPE]       = spe;
        c[CTRL_LOOP]      = loop;
        return c;
    endfunction

    // Sampling edges record MOSI, driving edges move MISO on
    always @(negedge clk) begin
        int idx;
        if (sclk_o != mon_prev) begin
            if ((sclk_o != cfg_cpol) == !cfg_cpha) begin
                mon_bits.push_back(mosi_o);
                mon_edges++;
            end else begin
                drv_edges++;
            end
            mon_prev = sclk_o;
        end
        idx = cfg_cpha ? drv_edges - 1 : drv_edges;
        if (idx < 0)
            idx = 0;
        if (idx >= cfg_width)
            idx = cfg_width - 1;
        miso_i = line_bit(miso_pat, cfg_width, cfg_lsb, idx);
    end

    task automatic arm_monitor(input logic cpol, input logic cpha, input logic lsb,
                               input int width, input logic [31:0] pat);
        @(posedge clk);
        #1;
        cfg_cpol  = cpol;
        cfg_cpha  = cpha;
        cfg_lsb   = lsb;
        cfg_width = width;
        miso_pat  = pat;
        mon_bits.delete();
        mon_edges = 0;
        drv_edges = 0;
        mon_prev  = sclk_o;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic host_write(input reg_addr_e addr, input logic [31:0] data);
        @(negedge clk);
        addr_i  = addr;
        wdata_i = data;
        wr_i    = 1'b1;
        @(negedge clk);
        wr_i    = 1'b0;
    endtask

    // Response expected exactly one cycle after the strobe
    task automatic host_read(input reg_addr_e addr, output logic [31:0] data);
        @(negedge clk);
        addr_i = addr;
        rd_i   = 1'b1;
        @(negedge clk);
        rd_i   = 1'b0;
        check_true(rvalid_o === 1'b1, "rvalid_o did not rise one cycle after rd_i");
        data = rdata_o;
        @(negedge clk);
        check_true(rvalid_o === 1'b0, "rvalid_o stayed high longer than one cycle");
    endtask

    task automatic wait_rx_word();
        logic [31:0] st;
        st = 32'h1;
        while (st[STAT_RX_EMPTY])
            host_read(ADDR_STATUS, st);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_values();
        int          e0;
        logic [31:0] v;
        e0 = errors;
        check_eq("ncs_o", 32'(ncs_o), 32'hF);
        host_read(ADDR_ID, v);
        check_eq("ID", v, 32'h294E_C100);
        host_read(ADDR_CTRL, v);
        check_eq("CTRL", v, 32'h0004_0820);
        host_read(ADDR_STATUS, v);
        check_eq("STATUS", v, 32'h0000_0005);
        host_read(ADDR_SS, v);
        check_eq("SS", v, 32'hFFFF_FFFF);
        report_test("reset_values", e0);
    endtask

    task automatic test_loopback();
        int          e0;
        int          widths[3];
        logic [31:0] tx;
        logic [31:0] rx;
        e0 = errors;
        widths = '{8, 13, 32};
        foreach (widths[i]) begin
            host_write(ADDR_CTRL, make_ctrl(2, widths[i], 1, 0, 0, 0, 1, 1));
            repeat (3) begin
                tx = next_random();
                host_write(ADDR_TXDATA, tx);
                wait_rx_word();
                host_read(ADDR_RXDATA, rx);
                check_eq("RXDATA", rx, tx & width_mask(widths[i]));
            end
        end
        report_test("loopback", e0);
    endtask

    task automatic test_wire_format();
        int          e0;
        int          width;
        logic        cpol;
        logic        cpha;
        logic [31:0] tx;
        logic [31:0] pat;
        logic [31:0] rx;
        e0 = errors;
        for (int mode = 0; mode < 4; mode++) begin
            for (int lsb = 0; lsb < 2; lsb++) begin
                cpol  = mode[1];
                cpha  = mode[0];
                width = 9 + mode;
                tx    = next_random() & width_mask(width);
                pat   = next_random() & width_mask(width);
                host_write(ADDR_CTRL, make_ctrl(2, width, 1, lsb[0], cpol, cpha, 1, 0));
                arm_monitor(cpol, cpha, lsb[0], width, pat);
                host_write(ADDR_TXDATA, tx);
                wait_rx_word();
                host_read(ADDR_RXDATA, rx);
                check_eq("sampling edges", 32'(mon_edges), 32'(width));
                for (int j = 0; j < width && j < mon_bits.size(); j++)
                    check_eq("mosi_o", 32'(mon_bits[j]), 32'(line_bit(tx, width, lsb[0], j)));
                check_eq("RXDATA", rx, pat);
                check_eq("sclk_o idle", 32'(sclk_o), 32'(cpol));
            end
        end
        report_test("wire_format", e0);
    endtask

    task automatic test_chip_selects();
        int          e0;
        logic        saw_low;
        logic [31:0] rx;
        e0 = errors;
        saw_low = 1'b0;
        host_write(ADDR_SS, 32'hFFFF_FFFA);
        host_write(ADDR_CTRL, make_ctrl(2, 8, 1, 0, 0, 0, 1, 1));
        @(negedge clk);
        check_eq("ncs_o", 32'(ncs_o), 32'hB);
        // Without MSSA the select follows the transfer
        host_write(ADDR_CTRL, make_ctrl(2, 8, 0, 0, 0, 0, 1, 1));
        check_eq("ncs_o", 32'(ncs_o), 32'hF);
        host_write(ADDR_TXDATA, 32'h5A);
        // Follow the select until it drops and rises again, 8 bits take about 32 cycles
        for (int c = 0; c < 200 && !(saw_low && ncs_o === 4'hF); c++) begin
            @(negedge clk);
            if (ncs_o !== 4'hF) begin
                saw_low = 1'b1;
                check_eq("ncs_o", 32'(ncs_o), 32'hB);
            end
        end
        check_true(saw_low, "chip select never went low during the transfer");
        check_eq("ncs_o", 32'(ncs_o), 32'hF);
        wait_rx_word();
        host_read(ADDR_RXDATA, rx);
        check_eq("RXDATA", rx, 32'h5A);
        host_write(ADDR_CTRL, make_ctrl(2, 8, 1, 0, 0, 0, 0, 1));
        check_eq("ncs_o", 32'(ncs_o), 32'hF);
        host_write(ADDR_SS, 32'hFFFF_FFFF);
        report_test("chip_selects", e0);
    endtask

    task automatic test_fifo_flush();
        int          e0;
        logic [31:0] st;
        logic [31:0] rx;
        logic [31:0] words[6];
        e0 = errors;
        host_write(ADDR_CTRL, make_ctrl(8, 8, 1, 0, 0, 0, 0, 1));
        for (int i = 0; i < 4; i++)
            host_write(ADDR_TXDATA, next_random());
        host_read(ADDR_STATUS, st);
        check_eq("STATUS", st, 32'h9);
        host_write(ADDR_TXDATA, next_random());
        host_read(ADDR_STATUS, st);
        check_eq("STATUS", st, 32'h9);
        host_read(ADDR_RXDATA, rx);
        check_eq("RXDATA", rx, 32'h0);
        host_write(ADDR_CTRL, make_ctrl(8, 8, 1, 0, 0, 0, 0, 1));
        host_read(ADDR_STATUS, st);
        check_eq("STATUS", st, 32'h5);
        // One word in flight, four queued, the sixth dropped
        host_write(ADDR_CTRL, make_ctrl(8, 8, 1, 0, 0, 0, 1, 1));
        foreach (words[i]) begin
            words[i] = next_random();
            host_write(ADDR_TXDATA, words[i]);
        end
        host_read(ADDR_STATUS, st);
        check_eq("STATUS.TX_FULL", 32'(st[STAT_TX_FULL]), 32'h1);
        for (int i = 0; i < 5; i++) begin
            wait_rx_word();
            host_read(ADDR_RXDATA, rx);
            check_eq("RXDATA", rx, words[i] & 32'hFF);
        end
        repeat (150) @(negedge clk);
        host_read(ADDR_STATUS, st);
        check_eq("STATUS", st, 32'h5);
        report_test("fifo_flush", e0);
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rng_state    = 32'hccf0_ffd1;
        cfg_cpol     = 1'b0;
        cfg_cpha     = 1'b0;
        cfg_lsb      = 1'b0;
        cfg_width    = 1;
        miso_pat     = '0;
        mon_prev     = 1'b0;
        mon_edges    = 0;
        drv_edges    = 0;
        reset_i      = 1'b1;
        addr_i       = ADDR_ID;
        wr_i         = 1'b0;
        wdata_i      = '0;
        rd_i         = 1'b0;
        miso_i       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        test_reset_values();
        test_loopback();
        test_wire_format();
        test_chip_selects();
        test_fifo_flush();

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut.u_assertions.fail_count);
        if (errors == 0 && tests_failed == 0 && dut.u_assertions.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: spi_master_assertions.sv
/* Concurrent checks on the serial engine and chip selects.
   Bound into the SPI master top level, where engine and register wires meet. */
`timescale 1ns/1ps

module spi_master_assertions #(
    parameter int NUM_SS = 1
) (
    input logic              clk,
    input logic              reset_i,
    input logic              enable_i,
    input logic              cpol_i,
    input logic              busy_i,
    input logic              sclk_i,
    input logic              tx_pop_i,
    input logic              tx_empty_i,
    input logic [NUM_SS-1:0] ncs_i
);

    // Number of failed checks
    int fail_count;

    // Idle SCLK sits at CPOL, or at 0 when disabled,
    // and stays there on the first cycle after a pop
    a_sclk_idle: assert property (@(posedge clk) disable iff (reset_i)
        (!busy_i || $past(tx_pop_i)) |-> (sclk_i == (enable_i && cpol_i)))
        else begin
            $error("SCLK left its idle level outside a transfer");
            fail_count++;
        end

    // A pop takes a real word and starts a transfer
    a_no_empty_pop: assert property (@(posedge clk) disable iff (reset_i)
        tx_pop_i |-> !tx_empty_i ##1 busy_i)
        else begin
            $error("transmit FIFO popped while empty or without starting a word");
            fail_count++;
        end

    a_busy_needs_enable: assert property (@(posedge clk) disable iff (reset_i)
        busy_i |-> enable_i)
        else begin
            $error("engine busy while disabled");
            fail_count++;
        end

    // One slave at a time
    a_one_select: assert property (@(posedge clk) disable iff (reset_i)
        $countones(~ncs_i) <= 1)
        else begin
            $error("more than one chip select low");
            fail_count++;
        end

endmodule

bind spi_master_top spi_master_assertions #(.NUM_SS(NUM_SS)) u_assertions (
    .clk(clk), .reset_i(reset_i), .enable_i(enable), .cpol_i(cpol), .busy_i(busy),
    .sclk_i(sclk_o), .tx_pop_i(tx_pop), .tx_empty_i(tx_empty), .ncs_i(ncs_o)
);

// File: spi_master_top.sv
/* SPI master top level with a simple strobe register port.
   Joins the register block, the transmit and receive FIFOs and the serial engine. */
`timescale 1ns/1ps

module spi_master_top #(
    parameter int NUM_SS     = 1,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  spi_pkg::reg_addr_e         addr_i,
    input  logic                       wr_i,
    input  logic [spi_pkg::DATA_W-1:0] wdata_i,
    input  logic                       rd_i,
    input  logic                       miso_i,
    output logic [spi_pkg::DATA_W-1:0] rdata_o,
    output logic                       rvalid_o,
    output logic                       sclk_o,
    output logic                       mosi_o,
    output logic [NUM_SS-1:0]          ncs_o
);
    import spi_pkg::*;

    // FIFO paths
    logic [DATA_W-1:0] tx_data;
    logic [DATA_W-1:0] tx_head;
    logic [DATA_W-1:0] rx_data;
    logic [DATA_W-1:0] rx_head;
    logic tx_push, tx_pop, tx_empty, tx_full;
    logic rx_push, rx_pop, rx_empty, rx_full;
    logic flush;
    logic busy;

    // Engine configuration
    logic enable, cpol, cpha, lsb_first, loop;
    logic [PRESCALE_W-1:0] prescale;
    logic [WIDTH_W-1:0]    word_width;

    spi_regs #(
        .NUM_SS (NUM_SS)
    ) u_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .addr_i       (addr_i),
        .wr_i         (wr_i),
        .wdata_i      (wdata_i),
        .rd_i         (rd_i),
        .tx_empty_i   (tx_empty),
        .tx_full_i    (tx_full),
        .rx_empty_i   (rx_empty),
        .rx_full_i    (rx_full),
        .rx_head_i    (rx_head),
        .busy_i       (busy),
        .rdata_o      (rdata_o),
        .rvalid_o     (rvalid_o),
        .tx_push_o    (tx_push),
        .tx_data_o    (tx_data),
        .rx_pop_o     (rx_pop),
        .flush_o      (flush),
        .enable_o     (enable),
        .cpol_o       (cpol),
        .cpha_o       (cpha),
        .lsb_first_o  (lsb_first),
        .loop_o       (loop),
        .prescale_o   (prescale),
        .word_width_o (word_width),
        .ncs_o        (ncs_o)
    );

    spi_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo (
        .clk(clk), .reset_i(reset_i), .flush_i(flush),
        .push_i(tx_push), .push_data_i(tx_data), .pop_i(tx_pop),
        .head_o(tx_head), .empty_o(tx_empty), .full_o(tx_full)
    );

    spi_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo (
        .clk(clk), .reset_i(reset_i), .flush_i(flush),
        .push_i(rx_push), .push_data_i(rx_data), .pop_i(rx_pop),
        .head_o(rx_head), .empty_o(rx_empty), .full_o(rx_full)
    );

    // Engine gates SCLK and MOSI itself when disabled
    spi_shift_engine u_engine (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush),
        .enable_i     (enable),
        .cpol_i       (cpol),
        .cpha_i       (cpha),
        .lsb_first_i  (lsb_first),
        .loop_i       (loop),
        .prescale_i   (prescale),
        .word_width_i (word_width),
        .tx_data_i    (tx_head),
        .tx_empty_i   (tx_empty),
        .miso_i       (miso_i),
        .tx_pop_o     (tx_pop),
        .rx_push_o    (rx_push),
        .rx_data_o    (rx_data),
        .busy_o       (busy),
        .sclk_o       (sclk_o),
        .mosi_o       (mosi_o)
    );

endmodule

// File: spi_shift_engine.sv
/* SPI serial engine for all four modes: pops transmit words, drives SCLK and MOSI,
   samples MISO and pushes each received word right-aligned. */
`timescale 1ns/1ps

module spi_shift_engine (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           flush_i,
    input  logic                           enable_i,
    input  logic                           cpol_i,
    input  logic                           cpha_i,
    input  logic                           lsb_first_i,
    input  logic                           loop_i,
    input  logic [spi_pkg::PRESCALE_W-1:0] prescale_i,
    input  logic [spi_pkg::WIDTH_W-1:0]    word_width_i,
    input  logic [spi_pkg::DATA_W-1:0]     tx_data_i,
    input  logic                           tx_empty_i,
    input  logic                           miso_i,
    output logic                           tx_pop_o,
    output logic                           rx_push_o,
    output logic [spi_pkg::DATA_W-1:0]     rx_data_o,
    output logic                           busy_o,
    output logic                           sclk_o,
    output logic                           mosi_o
);
    import spi_pkg::*;

    localparam int CNT_W = $clog2(DATA_W) + 1;

    eng_state_e          state;
    logic [PRESCALE_W-1:0] presc_cnt;
    logic [PRESCALE_W-1:0] half_last;
    logic [CNT_W-1:0]    bit_cnt;
    logic [CNT_W-1:0]    width_eff;
    logic [CNT_W-1:0]    pad;
    logic [DATA_W-1:0]   tx_shift;
    logic [DATA_W-1:0]   rx_shift;
    logic [DATA_W-1:0]   rx_next;
    logic [DATA_W-1:0]   load_word;
    logic                mosi_q;
    logic                sample_in;
    logic                start;
    logic                half_done;
    logic                last_bit;

    // Current output bit of a shift word
    function automatic logic out_bit(input logic [DATA_W-1:0] v, input logic lsb);
        return lsb ? v[0] : v[DATA_W-1];
    endfunction

    function automatic logic [DATA_W-1:0] advance(input logic [DATA_W-1:0] v, input logic lsb);
        return lsb ? (v >> 1) : (v << 1);
    endfunction

    // Width clamped to 1..DATA_W
    always_comb begin
        if (word_width_i == '0)
            width_eff = CNT_W'(1);
        else if (word_width_i > WIDTH_W'(DATA_W))
            width_eff = CNT_W'(DATA_W);
        else
            width_eff = word_width_i[CNT_W-1:0];
    end

    assign pad       = CNT_W'(DATA_W) - width_eff;
    // MSB-first words moved up so the first bit sits at the top
    assign load_word = lsb_first_i ? tx_data_i : (tx_data_i << pad);
    // Prescale of 0 acts as 1
    assign half_last = (prescale_i == '0) ? '0 : prescale_i - 1'b1;
    assign half_done = (presc_cnt == half_last);
    assign last_bit  = (bit_cnt == width_eff - 1'b1);

    assign start     = (state == ST_IDLE) && enable_i && !tx_empty_i && !flush_i;
    assign tx_pop_o  = start;
    assign busy_o    = (state != ST_IDLE);
    assign rx_push_o = (state == ST_DONE);

    // Loopback samples our own MOSI
    assign sample_in = loop_i ? mosi_q : miso_i;
    assign rx_next   = lsb_first_i ? {sample_in, rx_shift[DATA_W-1:1]}
                                   : {rx_shift[DATA_W-2:0], sample_in};
    assign rx_data_o = lsb_first_i ? (rx_shift >> pad) : rx_shift;

    // SCLK leaves idle level only in the second half-period
    assign sclk_o = enable_i && (cpol_i ^ (state == ST_TRAIL));
    assign mosi_o = enable_i && mosi_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= ST_IDLE;
            presc_cnt <= '0;
            bit_cnt   <= '0;
            mosi_q    <= 1'b0;
        end else if (flush_i || !enable_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        presc_cnt <= '0;
                        bit_cnt   <= '0;
                        state     <= ST_LEAD;
                        // CPHA 0 puts the first bit out before the leading edge
                        if (!cpha_i)
                            mosi_q <= out_bit(load_word, lsb_first_i);
                    end
                end
                ST_LEAD: begin
                    if (half_done) begin
                        presc_cnt <= '0;
                        state     <= ST_TRAIL;
                        if (cpha_i)
                            mosi_q <= out_bit(tx_shift, lsb_first_i);
                    end else begin
                        presc_cnt <= presc_cnt + 1'b1;
                    end
                end
                ST_TRAIL: begin
                    if (half_done) begin
                        presc_cnt <= '0;
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= ST_DONE;
                        end else begin
                            state <= ST_LEAD;
                            if (!cpha_i)
                                mosi_q <= out_bit(tx_shift, lsb_first_i);
                        end
                    end else begin
                        presc_cnt <= presc_cnt + 1'b1;
                    end
                end
                // Word pushed this cycle
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shift registers
    always_ff @(posedge clk) begin
        if (start) begin
            rx_shift <= '0;
            tx_shift <= cpha_i ? load_word : advance(load_word, lsb_first_i);
        end
        if (state == ST_LEAD && half_done) begin
            // Leading edge shifts for CPHA 1, samples for CPHA 0
            if (cpha_i)
                tx_shift <= advance(tx_shift, lsb_first_i);
            else
                rx_shift <= rx_next;
        end
        if (state == ST_TRAIL && half_done) begin
            if (cpha_i)
                rx_shift <= rx_next;
            else
                tx_shift <= advance(tx_shift, lsb_first_i);
        end
    end

endmodule

// File: spi_regs.sv
/* Register block of the SPI master: host strobes, control and slave-select state,
   status word and chip-select generation. */
`timescale 1ns/1ps

module spi_regs #(
    parameter int NUM_SS = 1
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  spi_pkg::reg_addr_e             addr_i,
    input  logic                           wr_i,
    input  logic [spi_pkg::DATA_W-1:0]     wdata_i,
    input  logic                           rd_i,
    input  logic                           tx_empty_i,
    input  logic                           tx_full_i,
    input  logic                           rx_empty_i,
    input  logic                           rx_full_i,
    input  logic [spi_pkg::DATA_W-1:0]     rx_head_i,
    input  logic                           busy_i,
    output logic [spi_pkg::DATA_W-1:0]     rdata_o,
    output logic                           rvalid_o,
    output logic                           tx_push_o,
    output logic [spi_pkg::DATA_W-1:0]     tx_data_o,
    output logic                           rx_pop_o,
    output logic                           flush_o,
    output logic                           enable_o,
    output logic                           cpol_o,
    output logic                           cpha_o,
    output logic                           lsb_first_o,
    output logic                           loop_o,
    output logic [spi_pkg::PRESCALE_W-1:0] prescale_o,
    output logic [spi_pkg::WIDTH_W-1:0]    word_width_o,
    output logic [NUM_SS-1:0]              ncs_o
);
    import spi_pkg::*;

    logic              mssa_q;
    logic [DATA_W-1:0] ss_q;
    logic [DATA_W-1:0] ctrl_word;
    logic [DATA_W-1:0] status_word;
    logic [DATA_W-1:0] rd_word;

    // Strobes straight from the host port
    assign flush_o   = wr_i && (addr_i == ADDR_CTRL);
    assign tx_push_o = wr_i && (addr_i == ADDR_TXDATA);
    assign tx_data_o = wdata_i;
    // Empty case filtered by the FIFO
    assign rx_pop_o  = rd_i && (addr_i == ADDR_RXDATA);

    // Control and slave-select registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_o     <= 1'b0;
            cpol_o       <= 1'b0;
            cpha_o       <= 1'b0;
            lsb_first_o  <= 1'b0;
            loop_o       <= 1'b0;
            mssa_q       <= DEF_MSSA;
            prescale_o   <= DEF_PRESCALE;
            word_width_o <= DEF_WORD_WIDTH;
            ss_q         <= '1;
        end else if (wr_i) begin
            case (addr_i)
                ADDR_CTRL: begin
                    // Flush request leaves the fields untouched
                    if (!wdata_i[CTRL_FLUSH]) begin
                        enable_o     <= wdata_i[CTRL_SPE];
                        cpol_o       <= wdata_i[CTRL_CPOL];
                        cpha_o       <= wdata_i[CTRL_CPHA];
                        lsb_first_o  <= wdata_i[CTRL_LSB_FIRST];
                        loop_o       <= wdata_i[CTRL_LOOP];
                        mssa_q       <= wdata_i[CTRL_MSSA];
                        prescale_o   <= wdata_i[CTRL_PRESC_LO +: PRESCALE_W];
                        word_width_o <= wdata_i[CTRL_WIDTH_LO +: WIDTH_W];
                    end
                end
                ADDR_SS: ss_q <= wdata_i;
                default: ;
            endcase
        end
    end

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_PRESC_LO +: PRESCALE_W] = prescale_o;
        ctrl_word[CTRL_WIDTH_LO +: WIDTH_W]    = word_width_o;
        ctrl_word[CTRL_MSSA]      = mssa_q;
        ctrl_word[CTRL_LSB_FIRST] = lsb_first_o;
        ctrl_word[CTRL_CPOL]      = cpol_o;
        ctrl_word[CTRL_CPHA]      = cpha_o;
        ctrl_word[CTRL_SPE]       = enable_o;
        ctrl_word[CTRL_LOOP]      = loop_o;

        status_word = '0;
        status_word[STAT_TX_FULL]  = tx_full_i;
        status_word[STAT_TX_EMPTY] = tx_empty_i;
        status_word[STAT_RX_FULL]  = rx_full_i;
        status_word[STAT_RX_EMPTY] = rx_empty_i;

        // Unmapped and write-only addresses read as zero
        case (addr_i)
            ADDR_ID:     rd_word = SPI_ID;
            ADDR_CTRL:   rd_word = ctrl_word;
            ADDR_STATUS: rd_word = status_word;
            ADDR_SS:     rd_word = ss_q;
            ADDR_RXDATA: rd_word = rx_empty_i ? '0 : rx_head_i;
            default:     rd_word = '0;
        endcase
    end

    // Read response one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset_i)
            rvalid_o <= 1'b0;
        else
            rvalid_o <= rd_i;
    end

    always_ff @(posedge clk) begin
        if (rd_i)
            rdata_o <= rd_word;
    end

    // Highest zero bit wins, later loop passes override earlier ones
    always_comb begin
        ncs_o = '1;
        for (int i = 0; i < NUM_SS; i++) begin
            if (!ss_q[i]) begin
                ncs_o    = '1;
                ncs_o[i] = !(enable_o && (mssa_q || busy_i));
            end
        end
    end

endmodule

// File: spi_fifo.sv
/* First-word-fall-through FIFO with synchronous flush.
   Instantiated twice by the top level, for transmit and receive words. */
`timescale 1ns/1ps

module spi_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic [spi_pkg::DATA_W-1:0] push_data_i,
    input  logic                       pop_i,
    output logic [spi_pkg::DATA_W-1:0] head_o,
    output logic                       empty_o,
    output logic                       full_o
);
    import spi_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    // Extra top bit separates full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    // Head always shown, valid when not empty
    assign head_o  = mem[rd_ptr[AW-1:0]];

    // Overflow and underflow requests dropped here
    assign do_push = push_i && !full_o && !flush_i;
    assign do_pop  = pop_i && !empty_o && !flush_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[AW-1:0]] <= push_data_i;
    end

endmodule

// File: spi_pkg.sv
/* Shared widths, register map, control and status bit positions for the SPI master.
   Imported by every design module and by the testbench. */
package spi_pkg;

    // Bus and field widths
    localparam int DATA_W     = 32;
    localparam int PRESCALE_W = 16;
    localparam int WIDTH_W    = 8;
    localparam int ADDR_W     = 8;

    // Register byte addresses
    typedef enum logic [ADDR_W-1:0] {
        ADDR_ID     = 8'h00,
        ADDR_CTRL   = 8'h20,
        ADDR_STATUS = 8'h28,
        ADDR_SS     = 8'h2C,
        ADDR_TXDATA = 8'h30,
        ADDR_RXDATA = 8'h34
    } reg_addr_e;

    // Fixed identification word
    localparam logic [DATA_W-1:0] SPI_ID = 32'h294E_C100;

    // Control register bits
    localparam int CTRL_LOOP      = 0;
    localparam int CTRL_SPE       = 1;
    localparam int CTRL_CPHA      = 2;
    localparam int CTRL_CPOL      = 3;
    localparam int CTRL_LSB_FIRST = 4;
    localparam int CTRL_MSSA      = 5;
    localparam int CTRL_FLUSH     = 6;
    // Low bit of word width and prescale fields
    localparam int CTRL_WIDTH_LO  = 8;
    localparam int CTRL_PRESC_LO  = 16;

    // Status register bits
    localparam int STAT_RX_EMPTY = 0;
    localparam int STAT_RX_FULL  = 1;
    localparam int STAT_TX_EMPTY = 2;
    localparam int STAT_TX_FULL  = 3;

    // Values after reset
    localparam logic [PRESCALE_W-1:0] DEF_PRESCALE   = 16'd4;
    localparam logic [WIDTH_W-1:0]    DEF_WORD_WIDTH = 8'd8;
    localparam logic                  DEF_MSSA       = 1'b1;

    // Serial engine states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LEAD,
        ST_TRAIL,
        ST_DONE
    } eng_state_e;

endpackage
